// File: spi_bank_consts.svh
`ifndef SPI_BANK_CONSTS_SVH
`define SPI_BANK_CONSTS_SVH

// Frame width, also the host data width
`define SPI_DATA_W 8

// Number of slave ports behind the host bus
`define SPI_NUM_PORTS 4
`define SPI_PORT_W 2

// Register address within one port
`define SPI_REG_W 2

// Register map of one port
`define SPI_REG_INTR_EN 2'd0
`define SPI_REG_READY 2'd1
`define SPI_REG_TX 2'd2
`define SPI_REG_RX 2'd3

`endif

// File: spi_bank_pkg.sv
`include "spi_bank_consts.svh"

package spi_bank_pkg;

   // One SPI frame or one host data word
   typedef logic [`SPI_DATA_W-1:0] spi_data_t;

   typedef logic [`SPI_PORT_W-1:0] port_idx_t;

   typedef logic [`SPI_REG_W-1:0] reg_addr_t;

   // Port index in the upper bits, register in the lower bits
   typedef logic [`SPI_PORT_W+`SPI_REG_W-1:0] host_addr_t;

   // Host decoder states
   typedef enum logic [1:0] {
      dec_idle,
      dec_access,
      dec_done
   } dec_state_t;

endpackage

// File: host_ctl_if.sv
`timescale 1ns/1ps
`include "spi_bank_consts.svh"

interface host_ctl_if import spi_bank_pkg::*; ();

   // Single-cycle access strobe
   logic strobe;

   // One bit per port, only the addressed port is set
   logic [`SPI_NUM_PORTS-1:0] port_sel;

   logic we;
   reg_addr_t reg_addr;
   spi_data_t wdata;

   modport decoder (
      output strobe,
      output port_sel,
      output we,
      output reg_addr,
      output wdata
   );

   modport port (
      input strobe,
      input port_sel,
      input we,
      input reg_addr,
      input wdata
   );

   // Merger only needs to know which port to sample
   modport merger (
      input strobe,
      input port_sel
   );

endinterface

// File: host_bus_decoder.sv
`timescale 1ns/1ps
`include "spi_bank_consts.svh"

module host_bus_decoder import spi_bank_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       req,
   input  logic       we,
   input  host_addr_t addr,
   input  spi_data_t  wdata,
   output logic       ack,
   host_ctl_if.decoder ctl
);

   dec_state_t state;
   logic strobe_q;

   // Request fields, captured once per transfer
   logic we_q;
   host_addr_t addr_q;
   spi_data_t wdata_q;
   port_idx_t port_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= dec_idle;
         strobe_q <= 1'b0;
      end else begin
         case (state)
            dec_idle: begin
               if (req) begin
                  state <= dec_access;
                  strobe_q <= 1'b1;
               end
            end
            // Two cycles here, strobe in the first, read data settles in the second
            dec_access: begin
               strobe_q <= 1'b0;
               if (!strobe_q) begin
                  state <= dec_done;
               end
            end
            dec_done: begin
               // Hold ack until the host lets go of req
               if (!req) begin
                  state <= dec_idle;
               end
            end
            default: begin
               state <= dec_idle;
               strobe_q <= 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == dec_idle && req) begin
         we_q <= we;
         addr_q <= addr;
         wdata_q <= wdata;
      end
   end

   assign port_q = addr_q[`SPI_PORT_W+`SPI_REG_W-1 -: `SPI_PORT_W];

   assign ack = (state == dec_done);

   assign ctl.strobe = strobe_q;
   assign ctl.port_sel = {{(`SPI_NUM_PORTS-1){1'b0}}, 1'b1} << port_q;
   assign ctl.we = we_q;
   assign ctl.reg_addr = addr_q[`SPI_REG_W-1:0];
   assign ctl.wdata = wdata_q;

   a_strobe_in_access: assert property (
      @(posedge clk) disable iff (rst)
      ctl.strobe |-> (state == dec_access) && !ack
   );

endmodule

// File: spi_slave_port.sv
`timescale 1ns/1ps
`include "spi_bank_consts.svh"

module spi_slave_port import spi_bank_pkg::*; #(
   parameter int unsigned port_idx = 0
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      sclk,
   input  logic      ss,
   input  logic      mosi,
   output logic      miso,
   host_ctl_if.port  ctl,
   output spi_data_t rd_data,
   output logic      irq_pulse
);

   // SPI clock domain
   spi_data_t rx_shift;
   spi_data_t tx_shift;

   // Host clock domain
   spi_data_t tx_hold;
   logic ss_meta;
   logic ss_sync;
   logic ss_prev;
   logic ss_rise;
   logic ready;
   logic intr_en;
   logic host_hit;
   logic ready_clr;

   // Receive enters at the top and arrives LSB first
   always_ff @(posedge sclk or posedge rst) begin
      if (rst) begin
         rx_shift <= '0;
      end else if (!ss) begin
         rx_shift <= {mosi, rx_shift[`SPI_DATA_W-1:1]};
      end
   end

   // Transmit reloads while deselected and shifts out while selected
   always_ff @(negedge sclk or posedge rst) begin
      if (rst) begin
         tx_shift <= '0;
      end else if (ss) begin
         tx_shift <= tx_hold;
      end else begin
         tx_shift <= tx_shift >> 1;
      end
   end

   assign miso = tx_shift[0];

   assign host_hit = ctl.strobe & ctl.port_sel[port_idx];
   assign ready_clr = host_hit & !ctl.we & (ctl.reg_addr == `SPI_REG_RX);

   // Slave select idles high
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ss_meta <= 1'b1;
         ss_sync <= 1'b1;
         ss_prev <= 1'b1;
      end else begin
         ss_meta <= ss;
         ss_sync <= ss_meta;
         ss_prev <= ss_sync;
      end
   end

   // End of frame seen behind the synchronizer
   assign ss_rise = ss_sync & !ss_prev;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready <= 1'b0;
      end else if (ready_clr) begin
         ready <= 1'b0;
      end else if (ss_rise) begin
         ready <= 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         intr_en <= 1'b0;
         irq_pulse <= 1'b0;
      end else begin
         if (host_hit && ctl.we && ctl.reg_addr == `SPI_REG_INTR_EN) begin
            intr_en <= ctl.wdata[0];
         end
         irq_pulse <= intr_en & ss_rise;
      end
   end

   always_ff @(posedge clk) begin
      if (host_hit && ctl.we && ctl.reg_addr == `SPI_REG_TX) begin
         tx_hold <= ctl.wdata;
      end
   end

   // Register read mux for the merger
   always_comb begin
      case (ctl.reg_addr)
         `SPI_REG_INTR_EN: rd_data = {{(`SPI_DATA_W-1){1'b0}}, intr_en};
         `SPI_REG_READY: rd_data = {{(`SPI_DATA_W-1){1'b0}}, ready};
         `SPI_REG_TX: rd_data = tx_hold;
         default: rd_data = rx_shift;
      endcase
   end

   // A receive read clears ready even when a frame ends in that cycle
   a_ready_clear_wins: assert property (
      @(posedge clk) disable iff (rst)
      ready_clr |=> !ready
   );

   a_irq_single_cycle: assert property (
      @(posedge clk) disable iff (rst)
      irq_pulse |=> !irq_pulse
   );

endmodule

// File: host_read_merger.sv
`timescale 1ns/1ps
`include "spi_bank_consts.svh"

module host_read_merger import spi_bank_pkg::*; (
   input  logic                            clk,
   input  logic                            rst,
   host_ctl_if.merger                      ctl,
   input  spi_data_t [`SPI_NUM_PORTS-1:0] rd_data_all,
   input  logic [`SPI_NUM_PORTS-1:0]      irq_pulse_all,
   output spi_data_t                       rdata,
   output logic                            irq
);

   spi_data_t sel_data;

   // One-hot select as an AND-OR tree
   always_comb begin
      sel_data = '0;
      for (int i = 0; i < `SPI_NUM_PORTS; i++) begin
         if (ctl.port_sel[i]) begin
            sel_data = sel_data | rd_data_all[i];
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rdata <= '0;
         irq <= 1'b0;
      end else begin
         // Held until the next access
         if (ctl.strobe) begin
            rdata <= sel_data;
         end
         irq <= |irq_pulse_all;
      end
   end

   a_port_sel_onehot: assert property (
      @(posedge clk) disable iff (rst)
      ctl.strobe |-> $onehot(ctl.port_sel)
   );

endmodule

// File: spi_slave_bank.sv
`timescale 1ns/1ps
`include "spi_bank_consts.svh"

module spi_slave_bank import spi_bank_pkg::*; (
   input  logic                      clk,
   input  logic                      rst,

   // Host register bus
   input  logic                      req,
   input  logic                      we,
   input  host_addr_t                addr,
   input  spi_data_t                 wdata,
   output logic                      ack,
   output spi_data_t                 rdata,

   // One SPI slave per port
   input  logic [`SPI_NUM_PORTS-1:0] sclk,
   input  logic [`SPI_NUM_PORTS-1:0] ss,
   input  logic [`SPI_NUM_PORTS-1:0] mosi,
   output logic [`SPI_NUM_PORTS-1:0] miso,

   output logic                      irq
);

   host_ctl_if ctl ();

   spi_data_t [`SPI_NUM_PORTS-1:0] rd_data_all;
   logic [`SPI_NUM_PORTS-1:0] irq_pulse_all;

   host_bus_decoder u_decoder (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .we    (we),
      .addr  (addr),
      .wdata (wdata),
      .ack   (ack),
      .ctl   (ctl.decoder)
   );

   for (genvar i = 0; i < `SPI_NUM_PORTS; i++) begin : g_port
      spi_slave_port #(
         .port_idx (i)
      ) u_port (
         .clk       (clk),
         .rst       (rst),
         .sclk      (sclk[i]),
         .ss        (ss[i]),
         .mosi      (mosi[i]),
         .miso      (miso[i]),
         .ctl       (ctl.port),
         .rd_data   (rd_data_all[i]),
         .irq_pulse (irq_pulse_all[i])
      );
   end

   host_read_merger u_merger (
      .clk           (clk),
      .rst           (rst),
      .ctl           (ctl.merger),
      .rd_data_all   (rd_data_all),
      .irq_pulse_all (irq_pulse_all),
      .rdata         (rdata),
      .irq           (irq)
   );

endmodule

// File: tb_spi_slave_bank.sv
`timescale 1ns/1ps
`include "spi_bank_consts.svh"

module tb_spi_slave_bank import spi_bank_pkg::*; ();

   logic clk = 1'b0;
   logic rst;
   logic req;
   logic we;
   host_addr_t addr;
   spi_data_t wdata;
   logic ack;
   spi_data_t rdata;
   logic [`SPI_NUM_PORTS-1:0] sclk;
   logic [`SPI_NUM_PORTS-1:0] ss;
   logic [`SPI_NUM_PORTS-1:0] mosi;
   logic [`SPI_NUM_PORTS-1:0] miso;
   logic irq;

   // One entry per trace operation
   string ops[$];
   int ports[$];
   int regs[$];
   int values[$];
   int expects[$];

   int errors = 0;
   int cycles = 0;
   int cycle_limit = 0;
   int irq_count = 0;
   logic irq_q = 1'b0;

   always #2 clk = ~clk;

   spi_slave_bank UUT (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .we    (we),
      .addr  (addr),
      .wdata (wdata),
      .ack   (ack),
      .rdata (rdata),
      .sclk  (sclk),
      .ss    (ss),
      .mosi  (mosi),
      .miso  (miso),
      .irq   (irq)
   );

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: the run passed its limit of %0d cycles", cycle_limit);
         $display("Errors found");
         $finish;
      end
   end

   // Each irq pulse is one cycle long and counted once
   always @(negedge clk) begin
      if (irq === 1'b1) begin
         irq_count++;
         assert (irq_q !== 1'b1) else begin
            $display("irq stayed high for more than one cycle at %0t ns", $time);
            errors++;
         end
      end
      irq_q = irq;
   end

   task automatic check_value(input string name, input spi_data_t got, input spi_data_t exp);
      assert (got === exp) else begin
         $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Four-phase transfer, called and left on a falling clock edge
   task automatic host_access(input logic wr, input int port, input int regn,
                              input spi_data_t data, input int hold,
                              output spi_data_t got);
      int wait_cycles;
      req = 1'b1;
      we = wr;
      addr = {port[`SPI_PORT_W-1:0], regn[`SPI_REG_W-1:0]};
      wdata = data;
      wait_cycles = 0;
      while (ack !== 1'b1 && wait_cycles < 10) begin
         @(negedge clk);
         wait_cycles++;
      end
      got = rdata;
      assert (ack === 1'b1) else begin
         $display("Transfer to port %0d register %0d aborted, ack never came", port, regn);
         errors++;
      end
      if (ack === 1'b1) begin
         // ack and rdata hold while the host keeps req high
         repeat (hold) begin
            @(negedge clk);
            check_value("ack", ack, 1);
            check_value("rdata", rdata, got);
         end
      end
      req = 1'b0;
      wait_cycles = 0;
      while (ack !== 1'b0 && wait_cycles < 10) begin
         @(negedge clk);
         wait_cycles++;
      end
      assert (ack === 1'b0) else begin
         $display("ack did not fall after req was released on port %0d", port);
         errors++;
      end
      we = 1'b0;
      addr = '0;
      wdata = '0;
   endtask

   task automatic half_period();
      repeat (4 + $urandom % 3) @(negedge clk);
   endtask

   // Slave samples on rising sclk and shifts out on falling sclk, LSB first
   task automatic spi_frame(input int port, input spi_data_t tx, output spi_data_t got);
      int i;
      // Falling edge with ss high loads the transmit holding register
      sclk[port] = 1'b1;
      half_period();
      sclk[port] = 1'b0;
      half_period();
      ss[port] = 1'b0;
      for (i = 0; i < `SPI_DATA_W; i++) begin
         mosi[port] = tx[i];
         half_period();
         got[i] = miso[port];
         sclk[port] = 1'b1;
         half_period();
         sclk[port] = 1'b0;
      end
      half_period();
      ss[port] = 1'b1;
      repeat (4) @(negedge clk);
   endtask

   initial begin
      int fd;
      int code;
      int p;
      int r;
      int v;
      int e;
      int seed;
      int start_errors;
      int start_irqs;
      int failed;
      string tok;
      spi_data_t got;

      seed = $urandom(93965);
      start_irqs = 0;
      failed = 0;
      rst = 1'b1;
      req = 1'b0;
      we = 1'b0;
      addr = '0;
      wdata = '0;
      sclk = '0;
      ss = '1;
      mosi = '0;

      fd = $fopen("spi_bank_trace.txt", "r");
      if (fd != 0) begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
               code = $fgets(tok, fd);
            end else begin
               code = $fscanf(fd, "%h %h %h %h", p, r, v, e);
               ops.push_back(tok);
               ports.push_back(p);
               regs.push_back(r);
               values.push_back(v);
               expects.push_back(e);
            end
         end
         $fclose(fd);
      end
      if (ops.size() == 0) begin
         $display("No operations could be read from spi_bank_trace.txt");
         errors++;
      end
      cycle_limit = ops.size() * 200;

      repeat (10) @(negedge clk);
      rst = 1'b0;

      foreach (ops[n]) begin
         start_errors = errors;
         if (ops[n] == "W") begin
            host_access(1'b1, ports[n], regs[n], values[n], 0, got);
         end else if (ops[n] == "R") begin
            host_access(1'b0, ports[n], regs[n], 8'h00, values[n], got);
            check_value("rdata", got, expects[n]);
         end else if (ops[n] == "S") begin
            start_irqs = irq_count;
            spi_frame(ports[n], values[n], got);
            check_value("miso", got, expects[n]);
         end else if (ops[n] == "I") begin
            repeat (8) @(negedge clk);
            check_value("irq pulse count", irq_count - start_irqs, expects[n]);
         end else begin
            $display("Unknown trace operation %s", ops[n]);
            errors++;
         end
         if (errors != start_errors) begin
            failed++;
         end
         $display("op %0d %s port %0d reg %0d: %s", n, ops[n], ports[n], regs[n],
                  (errors == start_errors) ? "pass" : "FAIL");
      end

      $display("%0d operations, %0d failed, %0d errors", ops.size(), failed, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: spi_bank_trace.txt
# op port reg value expected, numbers in hex; R value = extra cycles req is held
# W write, R read, S frame (value on mosi, expected on miso), I irq (expected pulse count)
R 0 1 0 00
R 1 1 0 00
R 2 1 0 00
R 3 1 0 00
R 0 3 0 00
R 1 3 0 00
R 2 3 0 00
R 3 3 0 00
R 0 0 0 00
R 1 0 0 00
R 2 0 0 00
R 3 0 0 00
W 1 0 01 00
R 1 0 3 01
W 1 2 a5 00
S 1 0 3c a5
I 0 0 00 01
R 1 1 2 01
R 0 1 0 00
R 2 1 0 00
R 1 3 4 3c
R 1 1 0 00
W 2 0 00 00
W 2 2 5a 00
S 2 0 c3 5a
I 0 0 00 00
R 2 3 0 c3
R 1 3 0 3c
R 3 3 0 00

// File: project.f
+incdir+.
spi_bank_pkg.sv
host_ctl_if.sv
host_bus_decoder.sv
spi_slave_port.sv
host_read_merger.sv
spi_slave_bank.sv
tb_spi_slave_bank.sv
